// ==== btb/btb.sv ====
`timescale 1ns/1ns

module btb
    import bpu_pkg::*;
#(
    parameter int INDEX_BITS = 4
) (
    input  logic            clk,
    input  logic            rst_n,

    // fetch and predecode
    input  logic [PC_W-1:0] fetch_pc,
    input  btype_e          inst_btype,

    // training from execute
    input  resolve_t        resolve,

    // prediction toward fetch
    output pred_t           pred
);

    localparam int DEPTH = 1 << INDEX_BITS;

    // bundle index sits just above the 8-byte offset
    logic [INDEX_BITS-1:0] fetch_idx;
    logic [INDEX_BITS-1:0] res_idx;

    // per-entry valid mask
    logic [DEPTH-1:0]      valid_q;

    // training decode
    logic                  tgt_wr;
    logic                  tgt_clr;
    logic                  dir_upd;

    // prediction internals
    logic [PC_W-1:0]       stored_tgt;
    logic                  guess_taken;
    logic                  hit;
    logic                  taken;

    assign fetch_idx = fetch_pc[INDEX_BITS+2:3];
    assign res_idx   = resolve.pc[INDEX_BITS+2:3];

    // install target on a taken branch whose target was missed
    assign tgt_wr  = resolve.valid & resolve.taken & resolve.addr_fail;
    // drop the entry when the bundle turned out not to branch
    assign tgt_clr = resolve.valid & (resolve.btype == BT_NONE);
    // direction machines learn from pc-relative branches only
    assign dir_upd = resolve.valid & (resolve.btype == BT_PCREL);

    // valid mask
    // install wins over clear at the same index
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (tgt_wr) begin
            valid_q[res_idx] <= 1'b1;
        end else if (tgt_clr) begin
            valid_q[res_idx] <= 1'b0;
        end
    end

    // target store
    btb_target_ram #(
        .INDEX_BITS (INDEX_BITS)
    ) u_target_ram (
        .clk       (clk),
        .rd_index  (fetch_idx),
        .rd_target (stored_tgt),
        .wr_en     (tgt_wr),
        .wr_index  (res_idx),
        .wr_target (resolve.tpc)
    );

    // global direction guess
    dir_predictor u_dir_predictor (
        .clk           (clk),
        .rst_n         (rst_n),
        .update        (dir_upd),
        .outcome_taken (resolve.taken),
        .dir_hit       (~resolve.dir_fail),
        .guess_taken   (guess_taken)
    );

    // no tags, an aliasing pc counts as a hit
    assign hit = valid_q[fetch_idx];

    // unconditional and indirect always go
    // pc-relative goes only on a taken guess
    always_comb begin
        taken = 1'b0;
        if (hit) begin
            case (inst_btype)
                BT_UNCOND, BT_INDIRECT: taken = 1'b1;
                BT_PCREL:               taken = guess_taken;
                default:                taken = 1'b0;
            endcase
        end
    end

    // fall through to the next bundle when not taken
    assign pred.hit   = hit;
    assign pred.taken = taken;
    assign pred.pc    = taken ? stored_tgt : fetch_pc + PC_W'(8);

    // a taken prediction needs a live entry behind it
    // ties the guess from dir_predictor to the valid mask
    taken_needs_hit_a: assert property (
        @(posedge clk) disable iff (!rst_n) pred.taken |-> pred.hit
    ) else $error("btb: taken prediction without a valid entry");

endmodule

// ==== btb/btb_target_ram.sv ====
`timescale 1ns/1ns

module btb_target_ram
    import bpu_pkg::*;
#(
    parameter int INDEX_BITS = 4
) (
    input  logic                  clk,

    // fetch side, asynchronous read
    input  logic [INDEX_BITS-1:0] rd_index,
    output logic [PC_W-1:0]       rd_target,

    // resolve side, clocked write
    input  logic                  wr_en,
    input  logic [INDEX_BITS-1:0] wr_index,
    input  logic [PC_W-1:0]       wr_target
);

    // number of target slots
    localparam int DEPTH = 1 << INDEX_BITS;

    // target store, one pc per bundle index
    logic [PC_W-1:0] mem [DEPTH];

    // combinational read for zero latency prediction
    // a same cycle write shows up only after the edge
    // so fetch sees the old target (write after read)
    assign rd_target = mem[rd_index];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_index] <= wr_target;
        end
    end

    // write address must be clean whenever a write is requested
    // an x here would corrupt an unknown slot
    // and the valid mask in btb would then disagree with the store
    wr_index_known_a: assert property (
        @(posedge clk) wr_en |-> !$isunknown(wr_index)
    ) else $error("btb_target_ram: write index has unknown bits");

endmodule

// ==== btb/dir_predictor.sv ====
`timescale 1ns/1ns

module dir_predictor (
    input  logic clk,
    input  logic rst_n,

    // training from a resolved pc-relative branch
    input  logic update,
    input  logic outcome_taken,
    input  logic dir_hit,

    // taken guess toward the prediction mux
    output logic guess_taken
);

    // easy and hard machine encodings
    // low bit clear means a taken state
    localparam logic [1:0] ST_TAKEN = 2'b00;
    localparam logic [1:0] ST_NOT   = 2'b01;
    localparam logic [1:0] WK_TAKEN = 2'b10;
    localparam logic [1:0] WK_NOT   = 2'b11;

    // chooser encodings
    // idle is static not taken
    localparam logic [1:0] CH_IDLE = 2'b00;
    localparam logic [1:0] CH_EASY = 2'b01;
    localparam logic [1:0] CH_HARD = 2'b10;
    localparam logic [1:0] CH_RESV = 2'b11;

    logic [1:0] easy_q;
    logic [1:0] easy_d;
    logic [1:0] hard_q;
    logic [1:0] hard_d;
    logic [1:0] score_q;
    logic [1:0] score_d;
    logic [1:0] chooser_q;

    // easy machine
    // flips straight to the weak state on the other side
    always_comb begin
        case (easy_q)
            ST_TAKEN, WK_TAKEN: easy_d = outcome_taken ? ST_TAKEN : WK_NOT;
            default:            easy_d = outcome_taken ? WK_TAKEN : ST_NOT;
        endcase
    end

    // hard machine
    // plain saturating walk, one step per outcome
    always_comb begin
        case (hard_q)
            ST_TAKEN: hard_d = outcome_taken ? ST_TAKEN : WK_TAKEN;
            WK_TAKEN: hard_d = outcome_taken ? ST_TAKEN : WK_NOT;
            WK_NOT:   hard_d = outcome_taken ? WK_TAKEN : ST_NOT;
            default:  hard_d = outcome_taken ? WK_NOT   : ST_NOT;
        endcase
    end

    // score
    // bit 1 set means the easy machine has earned the choice
    always_comb begin
        case (score_q)
            2'b00:   score_d = dir_hit ? 2'b00 : 2'b01;
            2'b01:   score_d = dir_hit ? 2'b00 : 2'b10;
            2'b10:   score_d = dir_hit ? 2'b11 : 2'b01;
            default: score_d = dir_hit ? 2'b11 : 2'b10;
        endcase
    end

    // machines and score move only on a pc-relative resolve
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            easy_q  <= WK_TAKEN;
            hard_q  <= WK_TAKEN;
            score_q <= 2'b00;
        end else if (update) begin
            easy_q  <= easy_d;
            hard_q  <= hard_d;
            score_q <= score_d;
        end
    end

    // chooser follows the score every cycle
    // one cycle behind it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            chooser_q <= CH_IDLE;
        end else begin
            chooser_q <= score_q[1] ? CH_EASY : CH_HARD;
        end
    end

    // taken guess from the selected machine
    always_comb begin
        case (chooser_q)
            CH_EASY: guess_taken = ~easy_q[0];
            CH_HARD: guess_taken = ~hard_q[0];
            // idle and the unused slot guess not taken
            default: guess_taken = 1'b0;
        endcase
    end

    // reserved strategy is never entered
    chooser_not_resv_a: assert property (
        @(posedge clk) disable iff (!rst_n) chooser_q != CH_RESV
    ) else $error("dir_predictor: chooser in reserved state");

endmodule

// ==== common/bpu_pkg.sv ====
package bpu_pkg;

    // program counter width
    localparam int PC_W = 32;

    // predecode branch type
    // low bit set means always taken
    typedef enum logic [1:0] {
        BT_NONE     = 2'b00,
        BT_UNCOND   = 2'b01,
        BT_PCREL    = 2'b10,
        BT_INDIRECT = 2'b11
    } btype_e;

    // one resolved bundle from execute
    typedef struct packed {
        logic            valid;
        btype_e          btype;
        // fact pc of the bundle
        logic [PC_W-1:0] pc;
        // actual target
        logic [PC_W-1:0] tpc;
        logic            taken;
        // direction guess was wrong
        logic            dir_fail;
        // target guess was wrong
        logic            addr_fail;
    } resolve_t;

    // prediction toward fetch
    typedef struct packed {
        logic            hit;
        logic            taken;
        logic [PC_W-1:0] pc;
    } pred_t;

    // resolution statistics
    typedef struct packed {
        logic [31:0] total;
        logic [31:0] dir_miss;
        logic [31:0] addr_miss;
    } stats_t;

endpackage

// ==== dv/bpu_tb.sv ====
`timescale 1ns/1ns

module bpu_tb
    import bpu_pkg::*;
();

    localparam int INDEX_BITS    = 4;
    localparam int DEPTH         = 1 << INDEX_BITS;
    localparam int HALF_PERIOD   = 20;
    localparam int RESET_CYCLES  = 5;
    localparam int RANDOM_CYCLES = 500;
    // directed phases plus the random run take about 620 cycles
    // limit is roughly three times that
    localparam int MAX_CYCLES    = 2000;

    // direction machine encodings
    // low bit clear is a taken state
    localparam logic [1:0] S_TAKEN = 2'b00;
    localparam logic [1:0] S_NOT   = 2'b01;
    localparam logic [1:0] W_TAKEN = 2'b10;
    localparam logic [1:0] W_NOT   = 2'b11;
    localparam logic [1:0] C_IDLE  = 2'b00;
    localparam logic [1:0] C_EASY  = 2'b01;
    localparam logic [1:0] C_HARD  = 2'b10;

    logic            clk;
    logic            rst_n;
    logic [PC_W-1:0] fetch_pc;
    btype_e          inst_btype;
    resolve_t        resolve;
    pred_t           pred;
    stats_t          stats;

    // reference model state
    logic            valid_m [DEPTH];
    logic [PC_W-1:0] tgt_m [DEPTH];
    logic [1:0]      easy_m;
    logic [1:0]      hard_m;
    logic [1:0]      score_m;
    logic [1:0]      chooser_m;
    int              total_m;
    int              dir_m;
    int              addr_m;

    pred_t           exp_pred;
    resolve_t        r;
    btype_e          bt;
    logic [31:0]     rnd;
    logic [31:0]     rnd2;
    integer          seed;
    int              checks = 0;
    int              errors = 0;
    int              other_errors = 0;
    int              cycle_cnt = 0;
    int              pcrel_taken_cnt = 0;
    int              easy_cycles = 0;

    bpu_top #(
        .INDEX_BITS (INDEX_BITS)
    ) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_pc   (fetch_pc),
        .inst_btype (inst_btype),
        .resolve    (resolve),
        .pred       (pred),
        .stats      (stats)
    );

    always #HALF_PERIOD clk = ~clk;

    // bundle pc from an index and the bits above it
    function automatic logic [PC_W-1:0] pc_for_index(input logic [INDEX_BITS-1:0] idx,
                                                     input logic [24:0] upper);
        return {upper, idx, 3'b000};
    endfunction

    function automatic resolve_t make_resolve(input btype_e b, input logic [PC_W-1:0] pc,
                                              input logic [PC_W-1:0] tpc, input logic tk,
                                              input logic df, input logic af);
        resolve_t x;
        x.valid     = 1'b1;
        x.btype     = b;
        x.pc        = pc;
        x.tpc       = tpc;
        x.taken     = tk;
        x.dir_fail  = df;
        x.addr_fail = af;
        return x;
    endfunction

    // expected prediction from the model state
    function automatic pred_t predict_expected(input logic [PC_W-1:0] pc, input btype_e b);
        pred_t p;
        logic [INDEX_BITS-1:0] idx;
        logic guess;
        idx   = pc[INDEX_BITS+2:3];
        guess = 1'b0;
        if (chooser_m == C_EASY) begin
            guess = (easy_m == S_TAKEN) || (easy_m == W_TAKEN);
        end else if (chooser_m == C_HARD) begin
            guess = (hard_m == S_TAKEN) || (hard_m == W_TAKEN);
        end
        p.hit   = valid_m[idx];
        p.taken = p.hit && ((b == BT_UNCOND) || (b == BT_INDIRECT) || ((b == BT_PCREL) && guess));
        p.pc    = p.taken ? tgt_m[idx] : pc + 32'd8;
        return p;
    endfunction

    task automatic clear_model();
        for (int i = 0; i < DEPTH; i++) begin
            valid_m[i] = 1'b0;
            tgt_m[i]   = '0;
        end
        easy_m    = W_TAKEN;
        hard_m    = W_TAKEN;
        score_m   = 2'b00;
        chooser_m = C_IDLE;
        total_m   = 0;
        dir_m     = 0;
        addr_m    = 0;
    endtask

    // one clock edge of model state
    task automatic advance_model(input resolve_t x);
        logic [INDEX_BITS-1:0] idx;
        logic [1:0] next_chooser;
        int lvl;
        idx = x.pc[INDEX_BITS+2:3];
        // chooser samples the score before this edge
        next_chooser = score_m[1] ? C_EASY : C_HARD;
        if (x.valid) begin
            if (x.taken && x.addr_fail) begin
                valid_m[idx] = 1'b1;
                tgt_m[idx]   = x.tpc;
            end else if (x.btype == BT_NONE) begin
                valid_m[idx] = 1'b0;
            end
            if (x.btype == BT_PCREL) begin
                // easy jumps across to the weak state of the other side
                if (x.taken) begin
                    easy_m = easy_m[0] ? W_TAKEN : S_TAKEN;
                end else begin
                    easy_m = easy_m[0] ? S_NOT : W_NOT;
                end
                // hard as a level
                // 0 strong not up to 3 strong taken
                case (hard_m)
                    S_NOT:   lvl = 0;
                    W_NOT:   lvl = 1;
                    W_TAKEN: lvl = 2;
                    default: lvl = 3;
                endcase
                if (x.taken && lvl < 3) begin
                    lvl++;
                end else if (!x.taken && lvl > 0) begin
                    lvl--;
                end
                case (lvl)
                    0:       hard_m = S_NOT;
                    1:       hard_m = W_NOT;
                    2:       hard_m = W_TAKEN;
                    default: hard_m = S_TAKEN;
                endcase
                // hit copies bit 1 into both bits
                // miss toggles between 01 and 10
                if (!x.dir_fail) begin
                    score_m = {2{score_m[1]}};
                end else begin
                    score_m = score_m[0] ? 2'b10 : 2'b01;
                end
            end
            total_m++;
            if (x.dir_fail) dir_m++;
            if (x.addr_fail) addr_m++;
        end
        chooser_m = next_chooser;
    endtask

    task automatic check_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] got_v);
        checks++;
        assert (got_v === exp_v) else begin
            errors++;
            $display("FAIL %s expected 0x%h got 0x%h at %0t", name, exp_v, got_v, $time);
        end
    endtask

    // one cycle of stimulus
    // applied on the falling edge
    task automatic drive_cycle(input logic [PC_W-1:0] pc, input btype_e b, input resolve_t x);
        @(negedge clk);
        fetch_pc   = pc;
        inst_btype = b;
        resolve    = x;
    endtask

    // compare just before the rising edge
    // then step the model
    always begin
        @(negedge clk);
        #(HALF_PERIOD - 1);
        if (!rst_n) begin
            clear_model();
        end else begin
            exp_pred = predict_expected(fetch_pc, inst_btype);
            check_field("pred.hit", exp_pred.hit, pred.hit);
            check_field("pred.taken", exp_pred.taken, pred.taken);
            check_field("pred.pc", exp_pred.pc, pred.pc);
            check_field("stats.total", total_m, stats.total);
            check_field("stats.dir_miss", dir_m, stats.dir_miss);
            check_field("stats.addr_miss", addr_m, stats.addr_miss);
            if (exp_pred.taken && inst_btype == BT_PCREL) pcrel_taken_cnt++;
            if (chooser_m == C_EASY) easy_cycles++;
            advance_model(resolve);
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        seed       = 32'he489_ee2f;
        clk        = 1'b0;
        rst_n      = 1'b0;
        fetch_pc   = '0;
        inst_btype = BT_NONE;
        resolve    = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // empty buffer
        // every fetch falls through
        for (int i = 0; i < 20; i++) begin
            rnd = $random(seed);
            drive_cycle({rnd[31:3], 3'b000}, btype_e'(rnd[1:0]), '0);
        end

        // install a target at every index
        for (int i = 0; i < DEPTH; i++) begin
            rnd = $random(seed);
            r = make_resolve(BT_UNCOND, pc_for_index(INDEX_BITS'(i), 25'h10),
                             {rnd[31:2], 2'b00}, 1'b1, 1'b0, 1'b1);
            drive_cycle(pc_for_index(INDEX_BITS'(i), 25'h0), BT_NONE, r);
        end
        // home pc and an alias with other upper bits
        for (int i = 0; i < DEPTH; i++) begin
            drive_cycle(pc_for_index(INDEX_BITS'(i), 25'h10), BT_UNCOND, '0);
            drive_cycle(pc_for_index(INDEX_BITS'(i), 25'h1abc), BT_INDIRECT, '0);
        end

        // clear even indices through non-branch resolves
        for (int i = 0; i < DEPTH; i += 2) begin
            r = make_resolve(BT_NONE, pc_for_index(INDEX_BITS'(i), 25'h3), '0, 1'b0, 1'b0, 1'b0);
            drive_cycle(pc_for_index(INDEX_BITS'(i), 25'h3), BT_NONE, r);
        end
        for (int i = 0; i < DEPTH; i++) begin
            drive_cycle(pc_for_index(INDEX_BITS'(i), 25'h3), BT_UNCOND, '0);
        end
        // install and clear in one record
        // install wins
        r = make_resolve(BT_NONE, pc_for_index(4'd2, 25'h0), 32'h0000_4440, 1'b1, 1'b0, 1'b1);
        drive_cycle(pc_for_index(4'd2, 25'h0), BT_NONE, r);
        drive_cycle(pc_for_index(4'd2, 25'h0), BT_INDIRECT, '0);

        // random training
        // mostly pc-relative
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            rnd  = $random(seed);
            rnd2 = $random(seed);
            bt = (rnd[3:2] != 2'b00) ? BT_PCREL : btype_e'(rnd[1:0]);
            r = make_resolve(bt, {rnd2[31:3], 3'b000}, {rnd2[15:0], rnd[31:18], 2'b00},
                             rnd[4], rnd[5], rnd[6] & rnd[7]);
            r.valid = (rnd[10:8] != 3'b000);
            drive_cycle({rnd2[31:7] ^ rnd[31:7], rnd[14:11], 3'b000},
                        rnd[15] ? BT_PCREL : btype_e'(rnd[17:16]), r);
        end

        // fetch at the index being written sees the old target first
        r = make_resolve(BT_UNCOND, pc_for_index(4'd5, 25'h7), 32'h0000_a000, 1'b1, 1'b0, 1'b1);
        drive_cycle(pc_for_index(4'd5, 25'h7), BT_UNCOND, r);
        r = make_resolve(BT_UNCOND, pc_for_index(4'd5, 25'h7), 32'h0000_b000, 1'b1, 1'b0, 1'b1);
        drive_cycle(pc_for_index(4'd5, 25'h7), BT_UNCOND, r);
        drive_cycle(pc_for_index(4'd5, 25'h7), BT_UNCOND, '0);
        // same on an empty entry
        // miss then hit
        r = make_resolve(BT_NONE, pc_for_index(4'd9, 25'h7), '0, 1'b0, 1'b0, 1'b0);
        drive_cycle(pc_for_index(4'd9, 25'h7), BT_NONE, r);
        r = make_resolve(BT_INDIRECT, pc_for_index(4'd9, 25'h7), 32'h0000_c000, 1'b1, 1'b0, 1'b1);
        drive_cycle(pc_for_index(4'd9, 25'h7), BT_UNCOND, r);
        drive_cycle(pc_for_index(4'd9, 25'h7), BT_UNCOND, '0);

        // let the last resolve reach the counters
        repeat (2) drive_cycle(32'h0, BT_NONE, '0);
        @(negedge clk);
        #HALF_PERIOD;

        assert (pcrel_taken_cnt > 0) else begin
            other_errors++;
            $display("no taken pc-relative prediction was seen");
        end
        assert (easy_cycles > 0) else begin
            other_errors++;
            $display("chooser never selected the easy machine");
        end

        $display("checks %0d, value errors %0d, other errors %0d", checks, errors, other_errors);
        if (errors == 0 && other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== rtl/bpu_stats.sv ====
`timescale 1ns/1ns

module bpu_stats
    import bpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    // resolved bundles from execute
    input  resolve_t resolve,

    // running counts
    output stats_t   stats
);

    // add one unless already all ones
    function automatic logic [31:0] sat_inc(input logic [31:0] cnt, input logic inc);
        logic [31:0] nxt;
        nxt = cnt;
        if (inc && (cnt != '1)) begin
            nxt = cnt + 32'd1;
        end
        return nxt;
    endfunction

    logic tot_inc;
    logic dir_inc;
    logic addr_inc;

    // each count moves only on a valid resolve
    assign tot_inc  = resolve.valid;
    assign dir_inc  = resolve.valid & resolve.dir_fail;
    assign addr_inc = resolve.valid & resolve.addr_fail;

    // counters land one edge after the resolve
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stats.total     <= '0;
            stats.dir_miss  <= '0;
            stats.addr_miss <= '0;
        end else begin
            stats.total     <= sat_inc(stats.total, tot_inc);
            stats.dir_miss  <= sat_inc(stats.dir_miss, dir_inc);
            stats.addr_miss <= sat_inc(stats.addr_miss, addr_inc);
        end
    end

    // a miss is always part of the total
    misses_within_total_a: assert property (
        @(posedge clk) disable iff (!rst_n)
            (stats.dir_miss <= stats.total) && (stats.addr_miss <= stats.total)
    ) else $error("bpu_stats: miss count above total");

endmodule

// ==== rtl/bpu_top.sv ====
`timescale 1ns/1ns

module bpu_top
    import bpu_pkg::*;
#(
    // 16 entries by default
    parameter int INDEX_BITS = 4
) (
    input  logic            clk,
    input  logic            rst_n,

    // fetch and predecode stage
    input  logic [PC_W-1:0] fetch_pc,
    input  btype_e          inst_btype,

    // execute stage, one record per cycle
    input  resolve_t        resolve,

    // back to fetch
    output pred_t           pred,

    // resolution counts
    output stats_t          stats
);

    // target buffer and direction guess
    btb #(
        .INDEX_BITS (INDEX_BITS)
    ) u_btb (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_pc   (fetch_pc),
        .inst_btype (inst_btype),
        .resolve    (resolve),
        .pred       (pred)
    );

    // resolve statistics
    // sees only the execute side
    bpu_stats u_bpu_stats (
        .clk     (clk),
        .rst_n   (rst_n),
        .resolve (resolve),
        .stats   (stats)
    );

endmodule

// ==== sources.f ====
common/bpu_pkg.sv
btb/btb_target_ram.sv
btb/dir_predictor.sv
btb/btb.sv
rtl/bpu_stats.sv
rtl/bpu_top.sv
dv/bpu_tb.sv
